// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = mips_system_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/avalon_if.sv
rtl/cpu_regfile.sv
rtl/cpu_alu.sv
rtl/cpu_core.sv
rtl/program_ram.sv
rtl/mips_system.sv
sim/mips_system_tb.sv

// File: rtl/avalon_if.sv
`timescale 1ns/1ps
`default_nettype none

interface avalon_if;

    logic [31:0] address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;
    logic        waitrequest;

    // master holds address and read until waitrequest drops.
    modport master (
        output address, read, write, writedata, byteenable,
        input  readdata, waitrequest
    );

    modport slave (
        input  address, read, write, writedata, byteenable,
        output readdata, waitrequest
    );

endinterface

`default_nettype wire

// File: rtl/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import mips_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire alu_op_t     op,
    input  wire logic [31:0] a,
    input  wire logic [31:0] b,
    input  wire logic [4:0]  shamt,
    input  wire logic        exec,
    output logic      [31:0] result
);

    logic [31:0] hi;
    logic [31:0] lo;
    logic [63:0] product;

    // unsigned product, both operands zero extended.
    assign product = 64'(a) * 64'(b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (exec && (op == ALU_MULTU)) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end
    end

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SLL: begin
                result = b << shamt;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_PASS_HI: begin
                result = hi;
            end
            ALU_PASS_LO: begin
                result = lo;
            end
            default: begin
                // multu writes HI/LO only.
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first fetch address, byte 4.
`define RESET_VECTOR 32'h0000_0004

// jr to this target halts after the delay slot.
`define HALT_ADDR 32'h0000_0000

// program store depth in 32-bit words.
`define MEM_WORDS 64

// cycles waitrequest stays high on each read.
`define WAIT_CYCLES 1

`endif

// File: rtl/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_core import mips_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    avalon_if.master         bus,
    output logic             active,
    output logic      [31:0] register_v0
);

    core_state_t state;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ir;
    logic        halt_pending;

    opcode_t     opcode;
    funct_t      funct;
    alu_op_t     alu_op;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [4:0]  wr_addr;
    logic        dec_wr;
    logic        is_jr;
    logic        fetch_done;

    assign opcode     = opcode_t'(ir[31:26]);
    assign funct      = funct_t'(ir[5:0]);
    assign fetch_done = (state == S_FETCH) && !bus.waitrequest;

    // read only, one word at a time.
    assign bus.address    = pc;
    assign bus.read       = (state == S_FETCH);
    assign bus.write      = 1'b0;
    assign bus.writedata  = '0;
    assign bus.byteenable = 4'b1111;

    always_comb begin
        alu_op  = ALU_ADD;
        alu_b   = rt_data;
        wr_addr = ir[15:11];
        dec_wr  = 1'b0;
        is_jr   = 1'b0;
        case (opcode)
            OP_ADDIU: begin
                alu_b   = {{16{ir[15]}}, ir[15:0]};
                wr_addr = ir[20:16];
                dec_wr  = 1'b1;
            end
            OP_SPECIAL: begin
                case (funct)
                    F_SLL:   begin alu_op = ALU_SLL;     dec_wr = 1'b1; end
                    F_ADDU:  begin alu_op = ALU_ADD;     dec_wr = 1'b1; end
                    F_XOR:   begin alu_op = ALU_XOR;     dec_wr = 1'b1; end
                    F_MFHI:  begin alu_op = ALU_PASS_HI; dec_wr = 1'b1; end
                    F_MFLO:  begin alu_op = ALU_PASS_LO; dec_wr = 1'b1; end
                    F_MULTU: begin alu_op = ALU_MULTU; end
                    F_JR:    begin is_jr = 1'b1; end
                    default: begin end
                endcase
            end
            default: begin end
        endcase
    end

    cpu_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (ir[25:21]),
        .rt_addr (ir[20:16]),
        .wr_addr (wr_addr),
        .wr_en   ((state == S_EXEC) && dec_wr),
        .wr_data (alu_result),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    cpu_alu u_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .op     (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (ir[10:6]),
        .exec   (state == S_EXEC),
        .result (alu_result)
    );

    // instruction register.
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            ir <= bus.readdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            active       <= 1'b0;
            pc           <= `RESET_VECTOR;
            next_pc      <= `RESET_VECTOR + 32'd4;
            halt_pending <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    state  <= S_FETCH;
                    active <= 1'b1;
                end
                S_FETCH: begin
                    if (fetch_done) begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    // pc walks one behind next_pc, which gives the delay slot.
                    pc      <= next_pc;
                    next_pc <= is_jr ? rs_data : next_pc + 32'd4;
                    if (halt_pending) begin
                        state  <= S_HALTED;
                        active <= 1'b0;
                    end else begin
                        state        <= S_FETCH;
                        halt_pending <= is_jr && (rs_data == `HALT_ADDR);
                    end
                end
                default: begin
                    active <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic [4:0]  rs_addr,
    input  wire logic [4:0]  rt_addr,
    input  wire logic [4:0]  wr_addr,
    input  wire logic        wr_en,
    input  wire logic [31:0] wr_data,
    output logic      [31:0] rs_data,
    output logic      [31:0] rt_data,
    output logic      [31:0] v0
);

    logic [31:0] regs [32];

    // $zero never takes a write, so it stays at its reset value.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[2];

endmodule

`default_nettype wire

// File: rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // primary opcode field, bits 31:26.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09
    } opcode_t;

    // funct field of SPECIAL instructions, bits 5:0.
    typedef enum logic [5:0] {
        F_SLL   = 6'h00,
        F_JR    = 6'h08,
        F_MFHI  = 6'h10,
        F_MFLO  = 6'h12,
        F_MULTU = 6'h19,
        F_ADDU  = 6'h21,
        F_XOR   = 6'h26
    } funct_t;

    // pass ops move HI or LO onto the result.
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SLL,
        ALU_XOR,
        ALU_PASS_HI,
        ALU_PASS_LO,
        ALU_MULTU
    } alu_op_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC,
        S_HALTED
    } core_state_t;

endpackage

`default_nettype wire

// File: rtl/mips_system.sv
`timescale 1ns/1ps
`default_nettype none

module mips_system (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        inst_input,
    input  wire logic [7:0]  inst_addr,
    input  wire logic [31:0] instruction,
    output logic             active,
    output logic      [31:0] register_v0
);

    // core to program store.
    avalon_if bus ();

    cpu_core u_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus.master),
        .active      (active),
        .register_v0 (register_v0)
    );

    // loader port only used while rst_n is low.
    program_ram u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus.slave),
        .inst_input  (inst_input),
        .inst_addr   (inst_addr),
        .instruction (instruction)
    );

endmodule

`default_nettype wire

// File: rtl/program_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module program_ram (
    input  wire logic        clk,
    input  wire logic        rst_n,
    avalon_if.slave          bus,
    input  wire logic        inst_input,
    input  wire logic [7:0]  inst_addr,
    input  wire logic [31:0] instruction
);

    localparam int AW = $clog2(`MEM_WORDS);
    localparam int CW = $clog2(`WAIT_CYCLES + 2);

    logic [31:0]   mem [`MEM_WORDS];
    logic [AW-1:0] bus_idx;
    logic [AW-1:0] load_idx;
    logic [CW-1:0] wait_cnt;
    logic          load_seen;

    // byte address divided by four.
    assign bus_idx  = bus.address[AW+1:2];
    assign load_idx = inst_addr[AW+1:2];

    // stall the first WAIT_CYCLES cycles of every read.
    assign bus.waitrequest = bus.read && (wait_cnt != CW'(`WAIT_CYCLES));
    assign bus.readdata    = mem[bus_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (bus.waitrequest) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    // marks that the loader has begun filling the store in this reset.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            load_seen <= 1'b0;
        end else if (inst_input) begin
            load_seen <= 1'b1;
        end
    end

    // cleared in reset until the first load, so empty words read as nop.
    always_ff @(posedge clk) begin
        if (inst_input) begin
            mem[load_idx] <= instruction;
        end else if (!rst_n && !load_seen) begin
            for (int w = 0; w < `MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (bus.write) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.byteenable[i]) begin
                    mem[bus_idx][8*i +: 8] <= bus.writedata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/mips_system_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module mips_system_tb;

    localparam int TRIALS         = 20;
    localparam int TIMEOUT_CYCLES = 200 * TRIALS;
    localparam int RESET_CYCLES   = 5;

    logic        clk;
    logic        rst_n;
    logic        inst_input;
    logic [7:0]  inst_addr;
    logic [31:0] instruction;
    logic        active;
    logic [31:0] register_v0;

    integer      seed;
    int          errors;
    int          checks;
    int          cycle_count;
    logic [31:0] prog [$];

    mips_system DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_input  (inst_input),
        .inst_addr   (inst_addr),
        .instruction (instruction),
        .active      (active),
        .register_v0 (register_v0)
    );

    always #10 clk = ~clk;

    // watchdog over the whole run.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, active never fell, core hung", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // I-type addiu word with opcode 0x09.
    function automatic logic [31:0] addiu_word(input logic [4:0] rt, input logic [4:0] rs,
                                               input logic [15:0] imm);
        return {6'h09, rs, rt, imm};
    endfunction

    function automatic logic [31:0] special_word(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] rd, input logic [4:0] shamt,
                                                 input logic [5:0] funct);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    // shift and add model of the unsigned multiply.
    function automatic logic [63:0] unsigned_product(input logic [31:0] x,
                                                     input logic [31:0] y);
        logic [63:0] acc;
        acc = '0;
        for (int k = 0; k < 32; k++) begin
            if (y[k]) begin
                acc = acc + ({32'd0, x} << k);
            end
        end
        return acc;
    endfunction

    // upper half pre-adjusted so the sign-extended lower half lands exactly.
    task automatic push_constant(input logic [4:0] rd, input logic [31:0] value);
        logic [15:0] upper;
        upper = value[31:16] + {15'd0, value[15]};
        prog.push_back(addiu_word(rd, 5'd0, upper));
        prog.push_back(special_word(5'd0, rd, rd, 5'd16, 6'h00));
        prog.push_back(addiu_word(rd, rd, value[15:0]));
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            inst_input  = 1'b1;
            inst_addr   = 8'(`RESET_VECTOR + 4 * i);
            instruction = prog[i];
        end
        @(negedge clk);
        inst_input = 1'b0;
    endtask

    task automatic run_trial(input int trial);
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] expected;
        logic [63:0] product;
        logic        use_xor;
        logic [4:0]  delay_rt;
        int          wait_count;
        op_a = $random(seed);
        op_b = $random(seed);
        if (trial % 4 == 2) begin
            op_a[31] = 1'b1;
            op_b[31] = 1'b1;
        end
        use_xor  = 1'($random(seed));
        delay_rt = 5'($random(seed));
        if (delay_rt == 5'd2) begin
            delay_rt = 5'd3;
        end
        product = unsigned_product(op_a, op_b);

        prog.delete();
        push_constant(5'd8, op_a);
        push_constant(5'd9, op_b);
        prog.push_back(special_word(5'd8, 5'd9, 5'd0, 5'd0, 6'h19));
        prog.push_back(special_word(5'd0, 5'd0, 5'd10, 5'd0, 6'h10));
        prog.push_back(special_word(5'd0, 5'd0, 5'd11, 5'd0, 6'h12));
        // filler aimed at $zero.
        prog.push_back(addiu_word(5'd0, 5'($random(seed)), 16'($random(seed))));
        if (trial % 5 < 2) begin
            // operand trial adds $zero to t0 or t1 into v0.
            prog.push_back(special_word((trial % 5 == 0) ? 5'd8 : 5'd9, 5'd0, 5'd2, 5'd0,
                                        6'h21));
            expected = (trial % 5 == 0) ? op_a : op_b;
        end else if (use_xor) begin
            prog.push_back(special_word(5'd10, 5'd11, 5'd2, 5'd0, 6'h26));
            expected = product[63:32] ^ product[31:0];
        end else begin
            prog.push_back(special_word(5'd10, 5'd11, 5'd2, 5'd0, 6'h21));
            expected = product[63:32] + product[31:0];
        end
        // jr to $zero halts after the delay slot.
        prog.push_back(special_word(5'd0, 5'd0, 5'd0, 5'd0, 6'h08));
        prog.push_back(addiu_word(delay_rt, 5'($random(seed)), 16'($random(seed))));

        @(negedge clk);
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        load_program();
        checks++;
        assert (!active && register_v0 == 32'd0) else begin
            errors++;
            $display("trial %0d: active or register_v0 not cleared during reset", trial);
        end

        rst_n = 1'b1;
        wait_count = 0;
        while (!active && wait_count < 4) begin
            @(negedge clk);
            wait_count++;
        end
        checks++;
        assert (active) else begin
            errors++;
            $display("trial %0d: active did not rise after reset was released", trial);
        end

        // halt shows as active falling.
        while (active) begin
            @(negedge clk);
        end
        checks++;
        assert (register_v0 == expected) else begin
            errors++;
            $display("[FAIL] register_v0 = %h, expected %h (trial %0d)",
                     register_v0, expected, trial);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        inst_input  = 1'b0;
        inst_addr   = 8'd0;
        instruction = 32'd0;
        seed        = 32'h8afb_5c80;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        for (int t = 0; t < TRIALS; t++) begin
            run_trial(t);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
